/* tb.f */
+incdir+hdl
+incdir+tb
hdl/st_pkg.sv
hdl/rtc_bus_if.sv
hdl/st_reset_clk.sv
hdl/st_rtc.sv
hdl/st_audio_mix.sv
hdl/st_glue_top.sv
tb/tb_st_glue.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ST glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_st_glue -f tb.f \
	--Mdir obj_dir -o tb_st_glue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_st_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# any check failure or timeout prints the fail message
if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0

/* tb/st_glue_model.svh */
//**********************************************************
// reference model for the glue testbench
//   reset outputs by clock edge after release
//   MFP fractional accumulator
//   RTC readback and audio mix
//**********************************************************

`ifndef ST_GLUE_MODEL_SVH
`define ST_GLUE_MODEL_SVH

`include "st_defs.svh"

// counter value seen at edge k, k = 1 is the first edge after release
function automatic int cnt_at(input int k);
	return (k <= int'(`ST_RESET_CNT_INIT)) ? int'(`ST_RESET_CNT_INIT) + 1 - k : 0;
endfunction

function automatic bit exp_sys(input int k);
	return cnt_at(k) != 0;
endfunction

// low from the assert point down to the release point
function automatic bit exp_mcu(input int k);
	return !(cnt_at(k) <= int'(`ST_MCU_RST_ASSERT) && cnt_at(k) >= int'(`ST_MCU_RST_RELEASE));
endfunction

// one edge of the divider, en is the enable seen after that edge
function automatic longint mfp_next(input longint acc, output bit en);
	en = acc >= longint'(`ST_SYSTEM_CLOCK);
	return en ? acc - `ST_SYSTEM_CLOCK + `ST_MFP_CLOCK : acc + `ST_MFP_CLOCK;
endfunction

function automatic nibble_t rtc_expect(input bit cs_n, input rtc_reg_e addr,
	input rtc_time_t t, input bit bank, input nibble_t scr);
	nibble_t dig [16];
	int      r;
	if (cs_n || t == '0)
		return 4'hf;
	for (int i = 0; i < 6; i++) begin
		r = (i < 3) ? 2 * i : 2 * i + 1; // weekday sits at 6
		dig[r]     = t[8 * i +: 4];
		dig[r + 1] = t[8 * i + 4 +: 4];
	end
	dig[6]  = t[51:48];
	dig[11] = dig[11] + `ST_RTC_YEAR_OFFSET; // wraps in 4 bits
	dig[13] = {3'b100, bank};
	dig[14] = 4'h0;
	dig[15] = 4'hc;
	return (bank && addr < mode) ? scr : dig[addr];
endfunction

// offset binary to signed, then scaled into 15 bits
function automatic mix_sample_t mix_expect(input ym_sample_t ym, input dma_sample_t dma);
	int ys;
	int ds;
	int wide;
	ys   = int'(ym) - 512;
	ds   = int'(dma) - 128;
	wide = ys * 16 + ((ys >> 6) & 15) + ds * 64 + ((ds >> 2) & 63);
	return wide[14:0];
endfunction

`endif

/* tb/tb_st_glue.sv */
//**********************************************************
// testbench for the ST glue top level
//   reset sequence and CPU reset instruction
//   MFP and PSG clock enables
//   RTC readback and audio mix against the model
//**********************************************************

`timescale 1ns/100ps

module tb_st_glue
	import st_pkg::*;
();

	`include "st_glue_model.svh"

	localparam int CLK_PERIOD  = 100;
	localparam int TEST_CYCLES = 300 + 60 + 2016 + 216 + 250 + 160; // per test in order
	localparam int WATCHDOG_NS = TEST_CYCLES * 5 / 4 * CLK_PERIOD;  // plus a quarter

	logic        clk_32, xsint, ext_reset_i, cpu_reset_n_i;
	logic        rtc_cs_n_i, rtc_wr_n_i;
	rtc_reg_e    rtc_addr_i;
	nibble_t     rtc_wdata_i, rtc_rdata_o;
	rtc_time_t   rtc_time_i;
	ym_sample_t  ym_i;
	dma_sample_t dma_l_i, dma_r_i;
	logic        sys_reset_o, periph_reset_o, mcu_reset_n_o, mfp_clk_en_o, psg_clk_en_o;
	mix_sample_t mix_l_o, mix_r_o;

	int      errors = 0;
	int      tests_run = 0;
	int      tests_failed = 0;
	bit      bank_m;          // model bank bit
	nibble_t scratch_m [16];  // model scratch nibbles

	st_glue_top dut0 (.*);

	initial begin
		clk_32 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_32 = ~clk_32;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, tests still running after %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, want, got);
		errors++;
	endtask

	// registered outputs settled and inputs change here
	task automatic next_cycle();
		@(posedge clk_32);
		#10;
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("test %s done, %0d errors", name, errors - errors_before);
		tests_run++;
		if (errors != errors_before)
			tests_failed++;
	endtask

	// 16 cycles of xsint low with no enable pulse
	task automatic pulse_xsint();
		xsint = 1'b0;
		repeat (16) begin
			next_cycle();
			if (sys_reset_o !== 1'b1)
				report_mismatch("sys_reset_o", 1, sys_reset_o);
			if (psg_clk_en_o !== 1'b0)
				report_mismatch("psg_clk_en_o", 0, psg_clk_en_o);
			if (mfp_clk_en_o !== 1'b0)
				report_mismatch("mfp_clk_en_o", 0, mfp_clk_en_o);
		end
		xsint = 1'b1;
	endtask

	task automatic check_reset_window(input int n);
		for (int k = 1; k <= n; k++) begin
			next_cycle();
			if (sys_reset_o !== exp_sys(k))
				report_mismatch("sys_reset_o", exp_sys(k), sys_reset_o);
			if (periph_reset_o !== exp_sys(k - 1)) // one edge behind
				report_mismatch("periph_reset_o", exp_sys(k - 1), periph_reset_o);
			if (mcu_reset_n_o !== exp_mcu(k))
				report_mismatch("mcu_reset_n_o", exp_mcu(k), mcu_reset_n_o);
		end
	endtask

	task automatic rtc_write(input rtc_reg_e addr, input nibble_t data);
		rtc_cs_n_i  = 1'b0;
		rtc_wr_n_i  = 1'b0;
		rtc_addr_i  = addr;
		rtc_wdata_i = data;
		next_cycle();
		if (addr == mode)
			bank_m = data[0];
		else
			scratch_m[addr] = data;
		rtc_cs_n_i = 1'b1;
		rtc_wr_n_i = 1'b1;
	endtask

	task automatic rtc_read(input bit cs_n, input rtc_reg_e addr);
		nibble_t want;
		rtc_cs_n_i = cs_n;
		rtc_addr_i = addr;
		@(negedge clk_32); // mid cycle read data settled
		want = rtc_expect(cs_n, addr, rtc_time_i, bank_m, scratch_m[addr]);
		if (rtc_rdata_o !== want)
			report_mismatch("rtc_rdata_o", want, rtc_rdata_o);
		next_cycle();
		rtc_cs_n_i = 1'b1;
	endtask

	task automatic check_mix(input ym_sample_t y, input dma_sample_t l, input dma_sample_t r);
		ym_i    = y;
		dma_l_i = l;
		dma_r_i = r;
		@(negedge clk_32);
		if (mix_l_o !== mix_expect(y, l))
			report_mismatch("mix_l_o", mix_expect(y, l), mix_l_o);
		if (mix_r_o !== mix_expect(y, r))
			report_mismatch("mix_r_o", mix_expect(y, r), mix_r_o);
		next_cycle();
	endtask

	initial begin
		int     e0;
		int     len;
		int     op;
		int     n_dut;
		int     n_model;
		bit     prev_n;
		bit     en;
		longint acc;
		void'($urandom(32'h8ef9fc07));
		xsint         = 1'b0;
		ext_reset_i   = 1'b0;
		cpu_reset_n_i = 1'b1;
		rtc_cs_n_i    = 1'b1;
		rtc_wr_n_i    = 1'b1;
		rtc_addr_i    = sec_lo;
		rtc_wdata_i   = 4'h0;
		rtc_time_i    = '0;
		ym_i          = 10'h200; // mid scale silence
		dma_l_i       = 8'h80;
		dma_r_i       = 8'h80;

		// reset sequence then again from an ext reset pulse
		e0 = errors;
		pulse_xsint();
		check_reset_window(140);
		ext_reset_i = 1'b1;
		repeat (4) next_cycle();
		ext_reset_i = 1'b0;
		check_reset_window(140);
		end_test("reset_sequence", e0);

		// RESET instruction with random low lengths
		e0     = errors;
		prev_n = 1'b1;
		repeat (4) begin
			len = 1 + $urandom % 8;
			for (int i = 0; i < len + 6; i++) begin
				cpu_reset_n_i = (i >= len);
				next_cycle();
				if (mcu_reset_n_o !== !(prev_n && !cpu_reset_n_i)) // falling edge only
					report_mismatch("mcu_reset_n_o", !(prev_n && !cpu_reset_n_i), mcu_reset_n_o);
				if (periph_reset_o !== !cpu_reset_n_i)
					report_mismatch("periph_reset_o", !cpu_reset_n_i, periph_reset_o);
				prev_n = cpu_reset_n_i;
			end
		end
		end_test("cpu_reset", e0);

		// MFP enable model runs from the xsint release
		e0      = errors;
		acc     = 0;
		n_dut   = 0;
		n_model = 0;
		pulse_xsint();
		repeat (2000) begin
			acc = mfp_next(acc, en);
			next_cycle();
			if (mfp_clk_en_o !== en)
				report_mismatch("mfp_clk_en_o", en, mfp_clk_en_o);
			if (mfp_clk_en_o === 1'b1)
				n_dut++;
			if (en)
				n_model++;
		end
		if (n_dut != n_model)
			report_mismatch("mfp_clk_en_o pulse count", n_model, n_dut);
		end_test("mfp_clock_enable", e0);

		// PSG enable pulses on edge 1 then every 16
		e0 = errors;
		pulse_xsint();
		for (int k = 1; k <= 200; k++) begin
			next_cycle();
			if (psg_clk_en_o !== ((k - 1) % 16 == 0))
				report_mismatch("psg_clk_en_o", ((k - 1) % 16 == 0), psg_clk_en_o);
		end
		end_test("psg_clock_enable", e0);

		// RTC starts in bank 0 after the reset above
		e0     = errors;
		bank_m = 1'b0;
		rtc_time_i = {20'($urandom), $urandom};
		for (int a = 0; a < 13; a++)
			rtc_write(rtc_reg_e'(a), nibble_t'($urandom));
		repeat (150) begin
			op = $urandom % 8;
			if (op == 0)
				rtc_time_i = {20'($urandom), $urandom};
			else if (op == 1)
				rtc_write(mode, nibble_t'($urandom)); // bank switch
			else if (op == 2)
				rtc_write(rtc_reg_e'($urandom % 16), nibble_t'($urandom));
			else
				rtc_read(op == 3, rtc_reg_e'($urandom % 16)); // op 3 deselected
		end
		rtc_time_i = '0; // no time hides the chip in both banks
		for (int b = 0; b < 2; b++) begin
			rtc_write(mode, nibble_t'(b));
			for (int a = 0; a < 16; a++)
				rtc_read(1'b0, rtc_reg_e'(a));
		end
		rtc_time_i = {20'($urandom), $urandom} | 52'h1;
		rtc_read(1'b0, mode);
		cpu_reset_n_i = 1'b0; // short periph reset
		next_cycle();
		cpu_reset_n_i = 1'b1;
		next_cycle();
		bank_m = 1'b0;
		rtc_read(1'b0, mode);
		end_test("rtc", e0);

		// audio extremes first
		e0 = errors;
		check_mix(10'h000, 8'h00, 8'h00);
		check_mix(10'h3ff, 8'hff, 8'hff);
		check_mix(10'h200, 8'h80, 8'h80);
		check_mix(10'h000, 8'hff, 8'h00);
		check_mix(10'h3ff, 8'h00, 8'hff);
		repeat (150)
			check_mix(ym_sample_t'($urandom), dma_sample_t'($urandom), dma_sample_t'($urandom));
		end_test("audio_mix", e0);

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* hdl/st_glue_top.sv */
//**********************************************************
// ST glue logic top level
//   reset and clock enable block
//   RTC register block on its bus interface
//   audio mixer
//**********************************************************

`timescale 1ns/100ps

module st_glue_top
	import st_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,          // system reset, active low
	input  logic        ext_reset_i,
	input  logic        cpu_reset_n_i,

	// RTC register bus
	input  logic        rtc_cs_n_i,
	input  logic        rtc_wr_n_i,
	input  rtc_reg_e    rtc_addr_i,
	input  nibble_t     rtc_wdata_i,
	input  rtc_time_t   rtc_time_i,     // from IO controller

	// sound samples
	input  ym_sample_t  ym_i,
	input  dma_sample_t dma_l_i,
	input  dma_sample_t dma_r_i,

	output logic        sys_reset_o,
	output logic        periph_reset_o,
	output logic        mcu_reset_n_o,
	output logic        mfp_clk_en_o,   // 2.4576 MHz enable
	output logic        psg_clk_en_o,   // 2 MHz enable
	output nibble_t     rtc_rdata_o,
	output mix_sample_t mix_l_o,
	output mix_sample_t mix_r_o
);

	rtc_bus_if rtc_bus ();

	// host side of the RTC bus comes straight from the pins
	assign rtc_bus.cs_n  = rtc_cs_n_i;
	assign rtc_bus.wr_n  = rtc_wr_n_i;
	assign rtc_bus.addr  = rtc_addr_i;
	assign rtc_bus.wdata = rtc_wdata_i;
	assign rtc_rdata_o   = rtc_bus.rdata;

	st_reset_clk u_reset_clk (
		.clk_32         ( clk_32         ),
		.xsint          ( xsint          ),
		.ext_reset_i    ( ext_reset_i    ),
		.cpu_reset_n_i  ( cpu_reset_n_i  ),
		.sys_reset_o    ( sys_reset_o    ),
		.periph_reset_o ( periph_reset_o ),
		.mcu_reset_n_o  ( mcu_reset_n_o  ),
		.mfp_clk_en_o   ( mfp_clk_en_o   ),
		.psg_clk_en_o   ( psg_clk_en_o   )
	);

	// bank bit follows the peripheral reset, like the other chips
	st_rtc u_rtc (
		.clk_32         ( clk_32         ),
		.xsint          ( xsint          ),
		.periph_reset_i ( periph_reset_o ),
		.time_i         ( rtc_time_i     ),
		.bus            ( rtc_bus.rtc    )
	);

	st_audio_mix u_audio (
		.ym_i    ( ym_i    ),
		.dma_l_i ( dma_l_i ),
		.dma_r_i ( dma_r_i ),
		.mix_l_o ( mix_l_o ),
		.mix_r_o ( mix_r_o )
	);

endmodule

/* hdl/st_audio_mix.sv */
//**********************************************************
// audio mixer
//   PSG and DMA sound samples to signed form
//   sign extension to 15 bits and per channel sum
//**********************************************************

`timescale 1ns/100ps

module st_audio_mix
	import st_pkg::*;
(
	input  ym_sample_t  ym_i,    // PSG, same on both sides
	input  dma_sample_t dma_l_i,
	input  dma_sample_t dma_r_i,
	output mix_sample_t mix_l_o,
	output mix_sample_t mix_r_o
);

	ym_sample_t  ym_s;     // two's complement
	dma_sample_t dma_l_s;
	dma_sample_t dma_r_s;
	mix_sample_t ym_w;     // widened
	mix_sample_t dma_l_w;
	mix_sample_t dma_r_w;

	// sign, value, then top bits repeated to fill the low end
	function automatic mix_sample_t widen_dma(input dma_sample_t s);
		widen_dma = {s[7], s, s[7:2]};
	endfunction

	// offset binary to signed
	assign ym_s    = ym_i - 10'h200;
	assign dma_l_s = dma_l_i - 8'h80;
	assign dma_r_s = dma_r_i - 8'h80;

	assign ym_w    = {ym_s[9], ym_s, ym_s[9:6]};
	assign dma_l_w = widen_dma(dma_l_s);
	assign dma_r_w = widen_dma(dma_r_s);

	// wraps at 15 bits, no clipping
	assign mix_l_o = ym_w + dma_l_w;
	assign mix_r_o = ym_w + dma_r_w;

endmodule

/* hdl/st_rtc.sv */
//**********************************************************
// RP5C15 style real-time clock registers
//   bank 0 decode of the BCD time from the IO controller
//   mode, test and reset registers
//   bank 1 scratch nibble memory
//**********************************************************

`timescale 1ns/100ps
`include "st_defs.svh"

module st_rtc
	import st_pkg::*;
(
	input  logic      clk_32,
	input  logic      xsint,
	input  logic      periph_reset_i, // clears bank select
	input  rtc_time_t time_i,         // zero means no valid time
	rtc_bus_if.rtc    bus
);

	logic    bank;          // 0 clock or 1 scratch
	logic    wr_en;
	nibble_t time_nib;      // bank 0 view
	nibble_t scratch [16];  // bank 1 nibbles

	assign wr_en = ~bus.cs_n & ~bus.wr_n & ~periph_reset_i;

	// bank bit written through the mode register
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			bank <= 1'b0;
		end else if (periph_reset_i) begin
			bank <= 1'b0;
		end else if (wr_en && bus.addr == mode) begin
			bank <= bus.wdata[0];
		end
	end

	// every other address lands in scratch memory
	always_ff @(posedge clk_32) begin
		if (wr_en && bus.addr != mode)
			scratch[bus.addr] <= bus.wdata;
	end

	// clock digits
	always_comb begin
		case (bus.addr)
			sec_lo:  time_nib = time_i[3:0];
			sec_hi:  time_nib = time_i[7:4];
			min_lo:  time_nib = time_i[11:8];
			min_hi:  time_nib = time_i[15:12];
			hour_lo: time_nib = time_i[19:16];
			hour_hi: time_nib = time_i[23:20];
			weekday: time_nib = time_i[51:48]; // top nibble of the packed time
			day_lo:  time_nib = time_i[27:24];
			day_hi:  time_nib = time_i[31:28];
			mon_lo:  time_nib = time_i[35:32];
			mon_hi:  time_nib = time_i[39:36];
			year_lo: time_nib = time_i[43:40] + `ST_RTC_YEAR_OFFSET; // 1980 epoch
			year_hi: time_nib = time_i[47:44];
			default: time_nib = 4'hf; // control regs decoded below
		endcase
	end

	// zero latency read mux
	always_comb begin
		if (bus.cs_n) begin
			bus.rdata = 4'hf; // idle bus
		end else if (time_i == '0) begin
			bus.rdata = 4'hf; // no time from IO controller hides the chip
		end else begin
			case (bus.addr)
				mode:      bus.rdata = {1'b1, 2'b00, bank};
				test:      bus.rdata = 4'h0;
				reset_reg: bus.rdata = 4'hc;
				default:   bus.rdata = bank ? scratch[bus.addr] : time_nib;
			endcase
		end
	end

endmodule

/* hdl/st_reset_clk.sv */
//**********************************************************
// reset sequencer and clock enables
//   system, peripheral and MCU reset from a down counter
//   fractional 2.4576 MHz MFP clock enable
//   divide by 16 PSG clock enable
//**********************************************************

`timescale 1ns/100ps
`include "st_defs.svh"

module st_reset_clk (
	input  logic clk_32,
	input  logic xsint,          // async system reset, active low
	input  logic ext_reset_i,    // restarts the sequence
	input  logic cpu_reset_n_i,  // 68000 RESET instruction output
	output logic sys_reset_o,
	output logic periph_reset_o,
	output logic mcu_reset_n_o,
	output logic mfp_clk_en_o,
	output logic psg_clk_en_o
);

	logic [6:0]                  reset_cnt;
	logic                        cpu_reset_n_d; // for falling edge detect
	logic [31:0]                 mfp_acc;
	logic [`ST_PSG_DIV_BITS-1:0] psg_div;

	// down counter, stops at zero
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			reset_cnt <= `ST_RESET_CNT_INIT;
		end else begin
			if (ext_reset_i)
				reset_cnt <= `ST_RESET_CNT_INIT; // hold while ext reset is high
			else if (reset_cnt != 7'd0)
				reset_cnt <= reset_cnt - 7'd1;
		end
	end

	// reset outputs follow the counter compare points
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sys_reset_o    <= 1'b1;
			periph_reset_o <= 1'b1;
			mcu_reset_n_o  <= 1'b1;
			cpu_reset_n_d  <= 1'b1;
		end else begin
			cpu_reset_n_d  <= cpu_reset_n_i;
			sys_reset_o    <= (reset_cnt != 7'd0);
			periph_reset_o <= sys_reset_o | ~cpu_reset_n_i; // one more cycle of lag

			// MCU sees only a short window, its clocks keep the RAM going
			if (reset_cnt == `ST_MCU_RST_ASSERT)
				mcu_reset_n_o <= 1'b0;
			else if (reset_cnt < `ST_MCU_RST_RELEASE)
				mcu_reset_n_o <= 1'b1;
			if (~cpu_reset_n_i & cpu_reset_n_d)
				mcu_reset_n_o <= 1'b0; // reset instruction, one cycle
		end
	end

	// fractional divider
	// accumulate MFP rate, wrap at system rate
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mfp_acc      <= 32'd0;
			mfp_clk_en_o <= 1'b0;
		end else begin
			mfp_clk_en_o <= 1'b0;
			if (mfp_acc < `ST_SYSTEM_CLOCK) begin
				mfp_acc <= mfp_acc + `ST_MFP_CLOCK;
			end else begin
				mfp_acc      <= mfp_acc - `ST_SYSTEM_CLOCK + `ST_MFP_CLOCK;
				mfp_clk_en_o <= 1'b1; // one tick of 2.4576 MHz
			end
		end
	end

	// free running PSG divider, pulse on wrap
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			psg_div      <= '0;
			psg_clk_en_o <= 1'b0;
		end else begin
			psg_clk_en_o <= (psg_div == '0); // first pulse right after release
			psg_div      <= psg_div + 1'b1;
		end
	end

endmodule

/* hdl/rtc_bus_if.sv */
//**********************************************************
// RTC register bus
//   chip select and write strobe levels, no handshake
//   host and rtc modports
//**********************************************************

`timescale 1ns/100ps

interface rtc_bus_if
	import st_pkg::*;
();
	logic     cs_n;  // low selects the RTC
	logic     wr_n;  // low with cs_n writes on the clock edge
	rtc_reg_e addr;  // register address
	nibble_t  wdata;
	nibble_t  rdata; // combinational, 4'hf when deselected

	modport host (output cs_n, wr_n, addr, wdata, input rdata);

	modport rtc (input cs_n, wr_n, addr, wdata, output rdata);

endinterface

/* hdl/st_pkg.sv */
//**********************************************************
// shared types for the ST glue logic
//   RTC register map enum
//   nibble and BCD time types
//   PSG, DMA sound and mixed sample types
//**********************************************************

package st_pkg;

	// RP5C15 register addresses, bank 0 view
	typedef enum logic [3:0] {
		sec_lo    = 4'h0,
		sec_hi    = 4'h1,
		min_lo    = 4'h2,
		min_hi    = 4'h3,
		hour_lo   = 4'h4,
		hour_hi   = 4'h5,
		weekday   = 4'h6,
		day_lo    = 4'h7,
		day_hi    = 4'h8,
		mon_lo    = 4'h9,
		mon_hi    = 4'ha,
		year_lo   = 4'hb,
		year_hi   = 4'hc,
		mode      = 4'hd, // bank bit lives here
		test      = 4'he,
		reset_reg = 4'hf
	} rtc_reg_e;

	typedef logic [3:0]  nibble_t;
	typedef logic [51:0] rtc_time_t;   // {wday, year, mon, day, hour, min, sec} BCD
	typedef logic [9:0]  ym_sample_t;  // unsigned, mid scale 10'h200
	typedef logic [7:0]  dma_sample_t; // unsigned, mid scale 8'h80
	typedef logic [14:0] mix_sample_t; // signed sum

endpackage

/* hdl/st_defs.svh */
//**********************************************************
// rate and count constants for the ST glue logic
//   system and MFP clock rates for the fractional divider
//   reset sequencer load value and MCU reset window
//   PSG divider length, RTC year fix
//**********************************************************

`ifndef ST_DEFS_SVH
`define ST_DEFS_SVH

// clock rates in Hz
`define ST_SYSTEM_CLOCK 32'd32_084_988 // clk_32 nominal
`define ST_MFP_CLOCK    32'd2_457_600  // MFP timer clock target

// reset sequencer, 7 bit down counter
`define ST_RESET_CNT_INIT  7'd127 // load value on xsint and ext reset
`define ST_MCU_RST_ASSERT  7'd10  // mcu reset goes low here
`define ST_MCU_RST_RELEASE 7'd8   // released below this

// sound chip enable, divide by 2**bits
`define ST_PSG_DIV_BITS 4

// year digit fix, GEMDOS counts from 1980
`define ST_RTC_YEAR_OFFSET 4'd2

`endif
